// File: hw/sched_pkg.sv
// scheduler shared definitions
package sched_pkg;

  // ====================
  // register file sizes
  // ====================

  localparam int ARCH_REG_NUM    = 32;
  localparam int PHY_REG_NUM_DEF = 64;

  // architectural register index
  typedef logic [4:0] areg_t;

  // physical register index, matches PHY_REG_NUM
  typedef logic [5:0] preg_t;

  typedef logic [31:0] pc_t;

  // privilege level
  typedef logic [1:0] plv_t;

  // level 3 is user mode
  localparam plv_t PLV_USER = 2'd3;

  // ====================
  // instruction classes
  // ====================

  typedef enum logic [2:0] {
    INSTR_ALU  = 3'd0,
    INSTR_MDU  = 3'd1,
    INSTR_MEM  = 3'd2,
    INSTR_BR   = 3'd3,
    INSTR_MISC = 3'd4,
    INSTR_PRIV = 3'd5
  } instr_type_e;

  // sub-op of the misc class
  typedef logic [1:0] misc_op_t;

  localparam misc_op_t MISC_NONE    = 2'd0;
  localparam misc_op_t MISC_SYSCALL = 2'd1;
  localparam misc_op_t MISC_BREAK   = 2'd2;

  // ====================
  // exception codes
  // ====================

  typedef logic [5:0] ecode_t;

  localparam ecode_t ECODE_INT = 6'h00;
  localparam ecode_t ECODE_SYS = 6'h0B;
  localparam ecode_t ECODE_BRK = 6'h0C;
  localparam ecode_t ECODE_INE = 6'h0D;
  localparam ecode_t ECODE_IPE = 6'h0E;

endpackage

// File: hw/free_list.sv
// physical register free list
`timescale 1ns/1ns

module free_list #(
  parameter int PHY_REG_NUM = sched_pkg::PHY_REG_NUM_DEF
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             alloc_i,
  input  logic             free_valid_i,
  input  sched_pkg::preg_t free_preg_i,
  output logic             empty_o,
  output sched_pkg::preg_t preg_o
);
  import sched_pkg::*;

  // registers above the identity range start out free
  localparam int FL_DEPTH = PHY_REG_NUM - ARCH_REG_NUM;
  localparam int PTR_W    = $clog2(FL_DEPTH);
  localparam int CNT_W    = $clog2(FL_DEPTH + 1);

  preg_t            fl_mem [FL_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FL_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign preg_o  = fl_mem[head_q];

  // ====================
  // storage
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= preg_t'(ARCH_REG_NUM + i);
      end
    end else if (flush_i) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= preg_t'(ARCH_REG_NUM + i);
      end
    end else if (free_valid_i) begin
      fl_mem[tail_q] <= free_preg_i;
    end
  end

  // ====================
  // pointers and count
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(FL_DEPTH);
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(FL_DEPTH);
    end else begin
      if (alloc_i) begin
        head_q <= ptr_inc(head_q);
      end
      if (free_valid_i) begin
        tail_q <= ptr_inc(tail_q);
      end
      case ({alloc_i, free_valid_i})
        2'b10:   count_q <= count_q - 1'b1;
        2'b01:   count_q <= count_q + 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // the top must hold off accepts once the list runs dry
  a_no_alloc_empty: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_i |-> !empty_o);

endmodule

// File: hw/rename_table.sv
// register alias table with busy bits
`timescale 1ns/1ns

module rename_table (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  // new mapping from stage 1
  input  logic             upd_i,
  input  sched_pkg::areg_t upd_areg_i,
  input  sched_pkg::preg_t upd_preg_i,
  // source lookup
  input  sched_pkg::areg_t src0_i,
  input  sched_pkg::areg_t src1_i,
  // writeback wakeup
  input  logic             wb_valid_i,
  input  sched_pkg::preg_t wb_preg_i,
  output sched_pkg::preg_t psrc0_o,
  output sched_pkg::preg_t psrc1_o,
  output sched_pkg::preg_t old_preg_o,
  output logic             src0_ready_o,
  output logic             src1_ready_o,
  output logic             old_valid_o
);
  import sched_pkg::*;

  localparam int PREG_NUM = 2 ** $bits(preg_t);

  preg_t               map_q [ARCH_REG_NUM];
  logic [PREG_NUM-1:0] busy_q;

  // r0 never waits, a same-cycle writeback counts as done
  function automatic logic operand_ready(input areg_t areg, input preg_t preg);
    return (areg == '0) || !busy_q[preg] || (wb_valid_i && (wb_preg_i == preg));
  endfunction

  // ====================
  // lookup
  // ====================

  assign psrc0_o      = map_q[src0_i];
  assign psrc1_o      = map_q[src1_i];
  assign src0_ready_o = operand_ready(src0_i, psrc0_o);
  assign src1_ready_o = operand_ready(src1_i, psrc1_o);

  // previous mapping of the destination goes to the commit side
  assign old_preg_o  = map_q[upd_areg_i];
  assign old_valid_o = upd_i;

  // ====================
  // update
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (flush_i) begin
      // back to identity mapping
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (upd_i) begin
      map_q[upd_areg_i] <= upd_preg_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      if (wb_valid_i) begin
        busy_q[wb_preg_i] <= 1'b0;
      end
      // fresh allocation wins over a stale writeback
      if (upd_i) begin
        busy_q[upd_preg_i] <= 1'b1;
      end
    end
  end

endmodule

// File: hw/excp_check.sv
// stage-1 exception priority check
`timescale 1ns/1ns

module excp_check (
  input  sched_pkg::instr_type_e type_i,
  input  sched_pkg::misc_op_t    misc_op_i,
  input  logic                   invalid_i,
  input  logic                   has_int_i,
  input  sched_pkg::plv_t        plv_i,
  input  logic                   in_excp_i,
  output logic                   excp_o,
  output sched_pkg::ecode_t      ecode_o
);
  import sched_pkg::*;

  logic is_priv;
  logic is_syscall;
  logic is_break;

  assign is_priv    = (type_i == INSTR_PRIV);
  assign is_syscall = (type_i == INSTR_MISC) && (misc_op_i == MISC_SYSCALL);
  assign is_break   = (type_i == INSTR_MISC) && (misc_op_i == MISC_BREAK);

  // interrupt > ine > ipe > sys > brk
  always_comb begin
    excp_o  = 1'b0;
    ecode_o = '0;
    if (in_excp_i) begin
      if (has_int_i) begin
        excp_o  = 1'b1;
        ecode_o = ECODE_INT;
      end else if (invalid_i) begin
        excp_o  = 1'b1;
        ecode_o = ECODE_INE;
      end else if (is_priv && (plv_i == PLV_USER)) begin
        // privileged op from user mode
        excp_o  = 1'b1;
        ecode_o = ECODE_IPE;
      end else if (is_syscall) begin
        excp_o  = 1'b1;
        ecode_o = ECODE_SYS;
      end else if (is_break) begin
        excp_o  = 1'b1;
        ecode_o = ECODE_BRK;
      end
    end
  end

endmodule

// File: hw/dispatch_queue.sv
// in-order dispatch queue
`timescale 1ns/1ns

module dispatch_queue #(
  parameter int DQ_DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  // write from stage 1
  input  logic                   wr_i,
  input  sched_pkg::pc_t         wr_pc_i,
  input  sched_pkg::instr_type_e wr_type_i,
  input  sched_pkg::preg_t       wr_psrc0_i,
  input  sched_pkg::preg_t       wr_psrc1_i,
  input  sched_pkg::preg_t       wr_pdest_i,
  input  logic                   wr_rdy0_i,
  input  logic                   wr_rdy1_i,
  // writeback wakeup
  input  logic                   wb_valid_i,
  input  sched_pkg::preg_t       wb_preg_i,
  output logic                   space2_o,
  // head
  output logic                   rd_valid_o,
  input  logic                   rd_ready_i,
  output sched_pkg::pc_t         rd_pc_o,
  output sched_pkg::instr_type_e rd_type_o,
  output sched_pkg::preg_t       rd_psrc0_o,
  output sched_pkg::preg_t       rd_psrc1_o,
  output sched_pkg::preg_t       rd_pdest_o
);
  import sched_pkg::*;

  localparam int PTR_W = $clog2(DQ_DEPTH);
  localparam int CNT_W = $clog2(DQ_DEPTH + 1);

  pc_t           pc_mem    [DQ_DEPTH];
  instr_type_e   type_mem  [DQ_DEPTH];
  preg_t         psrc0_mem [DQ_DEPTH];
  preg_t         psrc1_mem [DQ_DEPTH];
  preg_t         pdest_mem [DQ_DEPTH];
  logic [DQ_DEPTH-1:0] rdy0_q;
  logic [DQ_DEPTH-1:0] rdy1_q;

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             rd_fire;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full     = (count_q == CNT_W'(DQ_DEPTH));
  assign space2_o = (count_q <= CNT_W'(DQ_DEPTH - 2));

  // head leaves only with both operands woken
  assign rd_valid_o = (count_q != '0) && rdy0_q[head_q] && rdy1_q[head_q];
  assign rd_fire    = rd_valid_o && rd_ready_i;

  assign rd_pc_o    = pc_mem[head_q];
  assign rd_type_o  = type_mem[head_q];
  assign rd_psrc0_o = psrc0_mem[head_q];
  assign rd_psrc1_o = psrc1_mem[head_q];
  assign rd_pdest_o = pdest_mem[head_q];

  // ====================
  // entries and wakeup
  // ====================

  always_ff @(posedge clk) begin
    for (int i = 0; i < DQ_DEPTH; i++) begin
      if (wb_valid_i && (psrc0_mem[i] == wb_preg_i)) begin
        rdy0_q[i] <= 1'b1;
      end
      if (wb_valid_i && (psrc1_mem[i] == wb_preg_i)) begin
        rdy1_q[i] <= 1'b1;
      end
    end
    // incoming ready bits already include this cycle's writeback
    if (wr_i) begin
      pc_mem[tail_q]    <= wr_pc_i;
      type_mem[tail_q]  <= wr_type_i;
      psrc0_mem[tail_q] <= wr_psrc0_i;
      psrc1_mem[tail_q] <= wr_psrc1_i;
      pdest_mem[tail_q] <= wr_pdest_i;
      rdy0_q[tail_q]    <= wr_rdy0_i;
      rdy1_q[tail_q]    <= wr_rdy1_i;
    end
  end

  // ====================
  // pointers
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_i) begin
        tail_q <= ptr_inc(tail_q);
      end
      if (rd_fire) begin
        head_q <= ptr_inc(head_q);
      end
      case ({wr_i, rd_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // in_ready at the top reserves room for stage 1
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    wr_i && !flush_i |-> !full);

endmodule

// File: hw/scheduler.sv
// single-issue rename and dispatch front
`timescale 1ns/1ns

module scheduler #(
  parameter int PHY_REG_NUM = sched_pkg::PHY_REG_NUM_DEF,
  parameter int DQ_DEPTH    = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  // instruction input
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  sched_pkg::pc_t         in_pc_i,
  input  sched_pkg::instr_type_e in_type_i,
  input  sched_pkg::misc_op_t    in_misc_op_i,
  input  logic                   in_invalid_i,
  input  sched_pkg::areg_t       in_areg_dst_i,
  input  sched_pkg::areg_t       in_areg_src0_i,
  input  sched_pkg::areg_t       in_areg_src1_i,
  input  logic                   csr_has_int_i,
  input  sched_pkg::plv_t        csr_plv_i,
  input  logic                   wb_valid_i,
  input  sched_pkg::preg_t       wb_preg_i,
  input  logic                   free_valid_i,
  input  sched_pkg::preg_t       free_preg_i,
  // commit report
  output logic                   alloc_valid_o,
  output sched_pkg::pc_t         alloc_pc_o,
  output sched_pkg::areg_t       alloc_areg_o,
  output sched_pkg::preg_t       alloc_preg_o,
  output sched_pkg::preg_t       alloc_old_preg_o,
  output logic                   alloc_old_valid_o,
  output logic                   alloc_excp_o,
  output sched_pkg::ecode_t      alloc_ecode_o,
  // issue
  output logic                   issue_valid_o,
  input  logic                   issue_ready_i,
  output sched_pkg::pc_t         issue_pc_o,
  output sched_pkg::instr_type_e issue_type_o,
  output sched_pkg::preg_t       issue_psrc0_o,
  output sched_pkg::preg_t       issue_psrc1_o,
  output sched_pkg::preg_t       issue_pdest_o
);
  import sched_pkg::*;

  logic        fl_empty;
  logic        fl_alloc;
  preg_t       fl_preg;
  logic        dq_space2;
  logic        accept;
  logic        has_dst;
  preg_t       rt_psrc0;
  preg_t       rt_psrc1;
  logic        rt_rdy0;
  logic        rt_rdy1;
  logic        s1_valid;
  pc_t         s1_pc;
  instr_type_e s1_type;
  misc_op_t    s1_misc_op;
  logic        s1_invalid;
  areg_t       s1_dst;
  areg_t       s1_src0;
  areg_t       s1_src1;
  preg_t       s1_preg;
  logic        s1_has_dst;

  // ====================
  // stage 0
  // ====================

  assign in_ready_o = !fl_empty && dq_space2;
  assign accept     = in_valid_i && in_ready_o;
  assign has_dst    = (in_areg_dst_i != '0);
  assign fl_alloc   = accept && has_dst;

  free_list #(.PHY_REG_NUM(PHY_REG_NUM)) u_free_list (
    .clk(clk), .rst_n(rst_n), .flush_i(flush_i), .alloc_i(fl_alloc),
    .free_valid_i(free_valid_i), .free_preg_i(free_preg_i),
    .empty_o(fl_empty), .preg_o(fl_preg)
  );

  // ====================
  // stage 1
  // ====================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_pc      <= in_pc_i;
      s1_type    <= in_type_i;
      s1_misc_op <= in_misc_op_i;
      s1_invalid <= in_invalid_i;
      s1_dst     <= in_areg_dst_i;
      s1_src0    <= in_areg_src0_i;
      s1_src1    <= in_areg_src1_i;
      s1_has_dst <= has_dst;
      // r0 destination takes no register
      s1_preg    <= has_dst ? fl_preg : '0;
    end
  end

  rename_table u_rename_table (
    .clk(clk), .rst_n(rst_n), .flush_i(flush_i),
    .upd_i(s1_valid && s1_has_dst), .upd_areg_i(s1_dst), .upd_preg_i(s1_preg),
    .src0_i(s1_src0), .src1_i(s1_src1),
    .wb_valid_i(wb_valid_i), .wb_preg_i(wb_preg_i),
    .psrc0_o(rt_psrc0), .psrc1_o(rt_psrc1), .old_preg_o(alloc_old_preg_o),
    .src0_ready_o(rt_rdy0), .src1_ready_o(rt_rdy1), .old_valid_o(alloc_old_valid_o)
  );

  excp_check u_excp_check (
    .type_i(s1_type), .misc_op_i(s1_misc_op), .invalid_i(s1_invalid),
    .has_int_i(csr_has_int_i), .plv_i(csr_plv_i), .in_excp_i(s1_valid),
    .excp_o(alloc_excp_o), .ecode_o(alloc_ecode_o)
  );

  // every stage-1 instruction is reported, even when it excepts
  assign alloc_valid_o = s1_valid;
  assign alloc_pc_o    = s1_pc;
  assign alloc_areg_o  = s1_dst;
  assign alloc_preg_o  = s1_preg;

  // excepting instructions stay out of the queue
  dispatch_queue #(.DQ_DEPTH(DQ_DEPTH)) u_dispatch_queue (
    .clk(clk), .rst_n(rst_n), .flush_i(flush_i),
    .wr_i(s1_valid && !alloc_excp_o), .wr_pc_i(s1_pc), .wr_type_i(s1_type),
    .wr_psrc0_i(rt_psrc0), .wr_psrc1_i(rt_psrc1), .wr_pdest_i(s1_preg),
    .wr_rdy0_i(rt_rdy0), .wr_rdy1_i(rt_rdy1),
    .wb_valid_i(wb_valid_i), .wb_preg_i(wb_preg_i), .space2_o(dq_space2),
    .rd_valid_o(issue_valid_o), .rd_ready_i(issue_ready_i),
    .rd_pc_o(issue_pc_o), .rd_type_o(issue_type_o), .rd_psrc0_o(issue_psrc0_o),
    .rd_psrc1_o(issue_psrc1_o), .rd_pdest_o(issue_pdest_o)
  );

  // issue payload holds while the execution side stalls
  a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid_o && !issue_ready_i && !flush_i |=>
      issue_valid_o && $stable(issue_pc_o) && $stable(issue_pdest_o));

endmodule

// File: sim/sched_checker.sv
// scheduler result checker
`timescale 1ns/1ns

module sched_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  // DUT outputs under watch
  input  logic                   in_ready_i,
  input  logic                   alloc_valid_i,
  input  sched_pkg::pc_t         alloc_pc_i,
  input  sched_pkg::areg_t       alloc_areg_i,
  input  sched_pkg::preg_t       alloc_preg_i,
  input  sched_pkg::preg_t       alloc_old_preg_i,
  input  logic                   alloc_old_valid_i,
  input  logic                   alloc_excp_i,
  input  sched_pkg::ecode_t      alloc_ecode_i,
  input  logic                   issue_valid_i,
  input  logic                   issue_ready_i,
  input  sched_pkg::pc_t         issue_pc_i,
  input  sched_pkg::instr_type_e issue_type_i,
  input  sched_pkg::preg_t       issue_psrc0_i,
  input  sched_pkg::preg_t       issue_psrc1_i,
  input  sched_pkg::preg_t       issue_pdest_i,
  input  logic                   wb_valid_i,
  input  sched_pkg::preg_t       wb_preg_i,
  input  logic                   stall_chk_i,
  // expected item, one per accepted instruction
  input  logic                   exp_valid_i,
  input  logic [127:0]           exp_name_i,
  input  sched_pkg::pc_t         exp_pc_i,
  input  sched_pkg::areg_t       exp_areg_i,
  input  sched_pkg::preg_t       exp_preg_i,
  input  sched_pkg::preg_t       exp_old_preg_i,
  input  logic                   exp_old_valid_i,
  input  logic                   exp_excp_i,
  input  sched_pkg::ecode_t      exp_ecode_i,
  input  logic                   exp_issue_i,
  input  sched_pkg::preg_t       exp_psrc0_i,
  input  sched_pkg::preg_t       exp_psrc1_i,
  input  sched_pkg::instr_type_e exp_type_i,
  input  logic                   exp_wait_en_i,
  input  sched_pkg::preg_t       exp_wait_preg_i,
  output int                     tests_o,
  output int                     fails_o,
  output int                     errors_o,
  output int                     pending_o
);
  import sched_pkg::*;

  typedef struct packed {
    logic [127:0] name;
    pc_t          pc;
    areg_t        areg;
    preg_t        preg;
    preg_t        old_preg;
    logic         old_valid;
    logic         excp;
    ecode_t       ecode;
    logic         issue;
    preg_t        psrc0;
    preg_t        psrc1;
    instr_type_e  itype;
    logic         wait_en;
    preg_t        wait_preg;
    int           errs;
  } exp_t;

  exp_t       commit_q [$];
  exp_t       issue_q  [$];
  logic [63:0] woken = '0;
  int         cur_errs;

  initial begin
    tests_o  = 0;
    fails_o  = 0;
    errors_o = 0;
  end

  assign pending_o = commit_q.size() + issue_q.size();

  task automatic compare(input logic [127:0] name, input string field,
                         input logic [31:0] exp_val, input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Fail %0s %s expected 0x%0h actual 0x%0h", name, field, exp_val, act_val);
      errors_o++;
      cur_errs++;
    end
  endtask

  task automatic close_test(input logic [127:0] name, input int errs);
    tests_o++;
    if (errs == 0) begin
      $display("test %0s ok", name);
    end else begin
      fails_o++;
      $display("test %0s had %0d mismatches", name, errs);
    end
  endtask

  // ====================
  // compare on each edge
  // ====================

  always @(posedge clk) begin
    exp_t e;
    if (rst_n) begin
      if (exp_valid_i) begin
        e = '{exp_name_i, exp_pc_i, exp_areg_i, exp_preg_i, exp_old_preg_i, exp_old_valid_i,
              exp_excp_i, exp_ecode_i, exp_issue_i, exp_psrc0_i, exp_psrc1_i, exp_type_i,
              exp_wait_en_i, exp_wait_preg_i, 0};
        commit_q.push_back(e);
      end
      if (alloc_valid_i) begin
        if (commit_q.size() == 0) begin
          $display("commit report for pc 0x%0h arrived with nothing expected", alloc_pc_i);
          errors_o++;
        end else begin
          e = commit_q.pop_front();
          cur_errs = 0;
          compare(e.name, "alloc_pc", e.pc, alloc_pc_i);
          compare(e.name, "alloc_areg", 32'(e.areg), 32'(alloc_areg_i));
          compare(e.name, "alloc_preg", 32'(e.preg), 32'(alloc_preg_i));
          compare(e.name, "alloc_old_preg", 32'(e.old_preg), 32'(alloc_old_preg_i));
          compare(e.name, "alloc_old_valid", 32'(e.old_valid), 32'(alloc_old_valid_i));
          compare(e.name, "alloc_excp", 32'(e.excp), 32'(alloc_excp_i));
          compare(e.name, "alloc_ecode", 32'(e.ecode), 32'(alloc_ecode_i));
          // a fresh allocation must be written back again
          if (alloc_old_valid_i) begin
            woken[alloc_preg_i] = 1'b0;
          end
          e.errs = cur_errs;
          if (e.issue) begin
            issue_q.push_back(e);
          end else begin
            close_test(e.name, cur_errs);
          end
        end
      end
      if (issue_valid_i && issue_ready_i) begin
        if (issue_q.size() == 0) begin
          $display("issue of pc 0x%0h happened with nothing expected", issue_pc_i);
          errors_o++;
        end else begin
          e = issue_q.pop_front();
          cur_errs = e.errs;
          compare(e.name, "issue_pc", e.pc, issue_pc_i);
          compare(e.name, "issue_type", 32'(e.itype), 32'(issue_type_i));
          compare(e.name, "issue_psrc0", 32'(e.psrc0), 32'(issue_psrc0_i));
          compare(e.name, "issue_psrc1", 32'(e.psrc1), 32'(issue_psrc1_i));
          compare(e.name, "issue_pdest", 32'(e.preg), 32'(issue_pdest_i));
          if (e.wait_en && !woken[e.wait_preg]) begin
            $display("%0s issued before its source register was written back", e.name);
            errors_o++;
            cur_errs++;
          end
          close_test(e.name, cur_errs);
        end
      end
      if (wb_valid_i) begin
        woken[wb_preg_i] = 1'b1;
      end
      if (stall_chk_i && in_ready_i) begin
        $display("in_ready_o is high although the free list is empty");
        errors_o++;
      end
    end
  end

endmodule

// File: sim/tb_scheduler.sv
// scheduler testbench
`timescale 1ns/1ns

module tb_scheduler;
  import sched_pkg::*;

  localparam int N_TESTS   = 37;
  localparam int ACT_NONE  = 0;
  localparam int ACT_WB    = 1;
  localparam int ACT_FREE  = 2;
  localparam int ACT_FLUSH = 3;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        flush = 1'b0;
  logic        in_valid = 1'b0;
  pc_t         in_pc = '0;
  instr_type_e in_type = INSTR_ALU;
  misc_op_t    in_misc = MISC_NONE;
  logic        in_inv = 1'b0;
  areg_t       in_dst = '0;
  areg_t       in_s0 = '0;
  areg_t       in_s1 = '0;
  logic        has_int = 1'b0;
  plv_t        plv = '0;
  logic        wb_valid = 1'b0;
  preg_t       wb_preg = '0;
  logic        free_valid = 1'b0;
  preg_t       free_preg = '0;
  logic        issue_ready = 1'b0;
  logic        cur_rdyhi = 1'b0;
  logic        stall_chk = 1'b0;
  logic        exp_valid = 1'b0;
  int          tests;
  int          fails;
  int          errors;
  int          pending;

  logic        in_ready;
  logic        alloc_valid;
  logic        alloc_old_valid;
  logic        alloc_excp;
  logic        issue_valid;
  pc_t         alloc_pc;
  pc_t         issue_pc;
  areg_t       alloc_areg;
  preg_t       alloc_preg;
  preg_t       alloc_old_preg;
  preg_t       issue_psrc0;
  preg_t       issue_psrc1;
  preg_t       issue_pdest;
  ecode_t      alloc_ecode;
  instr_type_e issue_type;

  // ====================
  // stimulus table
  // ====================

  logic [127:0] t_name [N_TESTS];
  instr_type_e  t_type [N_TESTS];
  misc_op_t     t_misc [N_TESTS];
  logic         t_inv [N_TESTS];
  logic         t_int [N_TESTS];
  plv_t         t_plv [N_TESTS];
  areg_t        t_dst [N_TESTS];
  areg_t        t_s0 [N_TESTS];
  areg_t        t_s1 [N_TESTS];
  int           t_act [N_TESTS];
  preg_t        t_apreg [N_TESTS];
  logic         t_rdyhi [N_TESTS];
  preg_t        t_preg [N_TESTS];
  preg_t        t_old [N_TESTS];
  logic         t_oldv [N_TESTS];
  logic         t_excp [N_TESTS];
  ecode_t       t_ecode [N_TESTS];
  logic         t_issue [N_TESTS];
  preg_t        t_ps0 [N_TESTS];
  preg_t        t_ps1 [N_TESTS];
  logic         t_wait [N_TESTS];
  preg_t        t_wpreg [N_TESTS];
  int           n_add = 0;

  task automatic add_test(input logic [127:0] nm, input instr_type_e ty, input misc_op_t mo,
                          input logic inv, input logic intr, input plv_t pl, input areg_t d,
                          input areg_t s0, input areg_t s1, input int act, input preg_t ap,
                          input logic rh, input preg_t ep, input preg_t eo, input logic eov,
                          input logic ex, input ecode_t ec, input logic iss, input preg_t p0,
                          input preg_t p1, input logic we, input preg_t wp);
    t_name[n_add]  = nm;
    t_type[n_add]  = ty;
    t_misc[n_add]  = mo;
    t_inv[n_add]   = inv;
    t_int[n_add]   = intr;
    t_plv[n_add]   = pl;
    t_dst[n_add]   = d;
    t_s0[n_add]    = s0;
    t_s1[n_add]    = s1;
    t_act[n_add]   = act;
    t_apreg[n_add] = ap;
    t_rdyhi[n_add] = rh;
    t_preg[n_add]  = ep;
    t_old[n_add]   = eo;
    t_oldv[n_add]  = eov;
    t_excp[n_add]  = ex;
    t_ecode[n_add] = ec;
    t_issue[n_add] = iss;
    t_ps0[n_add]   = p0;
    t_ps1[n_add]   = p1;
    t_wait[n_add]  = we;
    t_wpreg[n_add] = wp;
    n_add++;
  endtask

  task automatic build_table();
    // renaming and dependency chain
    add_test("alu_r1", INSTR_ALU, MISC_NONE, 0, 0, 0, 1, 2, 3, ACT_NONE, 0, 0,
             32, 1, 1, 0, ECODE_INT, 1, 2, 3, 0, 0);
    add_test("alu_r1_reuse", INSTR_ALU, MISC_NONE, 0, 0, 0, 1, 1, 0, ACT_NONE, 0, 0,
             33, 32, 1, 0, ECODE_INT, 1, 32, 0, 1, 32);
    add_test("behind_dep", INSTR_ALU, MISC_NONE, 0, 0, 0, 4, 5, 6, ACT_WB, 32, 0,
             34, 4, 1, 0, ECODE_INT, 1, 5, 6, 0, 0);
    add_test("dst_r0", INSTR_MEM, MISC_NONE, 0, 0, 0, 0, 1, 4, ACT_WB, 33, 0,
             0, 0, 0, 0, ECODE_INT, 1, 33, 34, 1, 33);
    // exception priority
    add_test("exc_int", INSTR_MISC, MISC_SYSCALL, 0, 1, 0, 7, 0, 0, ACT_WB, 34, 0,
             35, 7, 1, 1, ECODE_INT, 0, 0, 0, 0, 0);
    add_test("exc_ine_over_ipe", INSTR_PRIV, MISC_NONE, 1, 0, 3, 8, 0, 0, ACT_NONE, 0, 0,
             36, 8, 1, 1, ECODE_INE, 0, 0, 0, 0, 0);
    add_test("exc_ipe", INSTR_PRIV, MISC_NONE, 0, 0, 3, 9, 0, 0, ACT_NONE, 0, 0,
             37, 9, 1, 1, ECODE_IPE, 0, 0, 0, 0, 0);
    add_test("priv_plv0", INSTR_PRIV, MISC_NONE, 0, 0, 0, 10, 0, 0, ACT_NONE, 0, 0,
             38, 10, 1, 0, ECODE_INT, 1, 0, 0, 0, 0);
    add_test("exc_sys", INSTR_MISC, MISC_SYSCALL, 0, 0, 0, 11, 0, 0, ACT_NONE, 0, 0,
             39, 11, 1, 1, ECODE_SYS, 0, 0, 0, 0, 0);
    add_test("exc_brk", INSTR_MISC, MISC_BREAK, 0, 0, 0, 12, 0, 0, ACT_NONE, 0, 0,
             40, 12, 1, 1, ECODE_BRK, 0, 0, 0, 0, 0);
    add_test("int_over_brk", INSTR_MISC, MISC_BREAK, 0, 1, 0, 0, 0, 0, ACT_NONE, 0, 0,
             0, 0, 0, 1, ECODE_INT, 0, 0, 0, 0, 0);
    add_test("sys_user", INSTR_MISC, MISC_SYSCALL, 0, 0, 3, 13, 0, 0, ACT_NONE, 0, 0,
             41, 13, 1, 1, ECODE_SYS, 0, 0, 0, 0, 0);
    // the excepting r7 writer still left 35 busy
    add_test("rdy_hi_chain", INSTR_ALU, MISC_NONE, 0, 0, 0, 1, 1, 7, ACT_WB, 35, 1,
             42, 33, 1, 0, ECODE_INT, 1, 33, 35, 1, 35);
    add_test("mdu_chain", INSTR_MDU, MISC_NONE, 0, 0, 0, 2, 1, 0, ACT_WB, 42, 1,
             43, 2, 1, 0, ECODE_INT, 1, 42, 0, 1, 42);
    // drain the free list, the last one releases 33
    for (int k = 0; k < 20; k++) begin
      add_test({"fill_", 8'd48 + 8'(k / 10), 8'd48 + 8'(k % 10)}, INSTR_ALU, MISC_NONE,
               0, 0, 0, areg_t'(12 + k), 0, 0, (k == 19) ? ACT_FREE : ACT_NONE, 33, 1,
               preg_t'(44 + k), (k == 0) ? 6'd40 : (k == 1) ? 6'd41 : preg_t'(12 + k),
               1, 0, ECODE_INT, 1, 0, 0, 0, 0);
    end
    add_test("after_release", INSTR_ALU, MISC_NONE, 0, 0, 0, 5, 0, 0, ACT_FLUSH, 0, 1,
             33, 5, 1, 0, ECODE_INT, 1, 0, 0, 0, 0);
    // identity mapping again after flush
    add_test("flush_dst3", INSTR_ALU, MISC_NONE, 0, 0, 0, 3, 3, 1, ACT_NONE, 0, 0,
             32, 3, 1, 0, ECODE_INT, 1, 3, 1, 0, 0);
    add_test("flush_dst3_dep", INSTR_BR, MISC_NONE, 0, 0, 0, 3, 3, 0, ACT_WB, 32, 0,
             33, 32, 1, 0, ECODE_INT, 1, 32, 0, 1, 32);
  endtask

  always #10 clk = ~clk;

  // stalls on every other cycle unless the entry asks for a free execution side
  always @(posedge clk) begin
    if (!rst_n) begin
      issue_ready <= 1'b0;
    end else begin
      issue_ready <= cur_rdyhi ? 1'b1 : !issue_ready;
    end
  end

  scheduler #(.PHY_REG_NUM(PHY_REG_NUM_DEF), .DQ_DEPTH(8)) DUT (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .in_valid_i(in_valid), .in_ready_o(in_ready), .in_pc_i(in_pc), .in_type_i(in_type),
    .in_misc_op_i(in_misc), .in_invalid_i(in_inv), .in_areg_dst_i(in_dst),
    .in_areg_src0_i(in_s0), .in_areg_src1_i(in_s1),
    .csr_has_int_i(has_int), .csr_plv_i(plv),
    .wb_valid_i(wb_valid), .wb_preg_i(wb_preg),
    .free_valid_i(free_valid), .free_preg_i(free_preg),
    .alloc_valid_o(alloc_valid), .alloc_pc_o(alloc_pc), .alloc_areg_o(alloc_areg),
    .alloc_preg_o(alloc_preg), .alloc_old_preg_o(alloc_old_preg),
    .alloc_old_valid_o(alloc_old_valid), .alloc_excp_o(alloc_excp),
    .alloc_ecode_o(alloc_ecode),
    .issue_valid_o(issue_valid), .issue_ready_i(issue_ready), .issue_pc_o(issue_pc),
    .issue_type_o(issue_type), .issue_psrc0_o(issue_psrc0), .issue_psrc1_o(issue_psrc1),
    .issue_pdest_o(issue_pdest)
  );

  // expected item of the entry being applied
  int drv_idx = 0;

  sched_checker chk (
    .clk(clk), .rst_n(rst_n), .in_ready_i(in_ready),
    .alloc_valid_i(alloc_valid), .alloc_pc_i(alloc_pc), .alloc_areg_i(alloc_areg),
    .alloc_preg_i(alloc_preg), .alloc_old_preg_i(alloc_old_preg),
    .alloc_old_valid_i(alloc_old_valid), .alloc_excp_i(alloc_excp),
    .alloc_ecode_i(alloc_ecode),
    .issue_valid_i(issue_valid), .issue_ready_i(issue_ready), .issue_pc_i(issue_pc),
    .issue_type_i(issue_type),
    .issue_psrc0_i(issue_psrc0), .issue_psrc1_i(issue_psrc1), .issue_pdest_i(issue_pdest),
    .wb_valid_i(wb_valid), .wb_preg_i(wb_preg), .stall_chk_i(stall_chk),
    .exp_valid_i(exp_valid), .exp_name_i(t_name[drv_idx]),
    .exp_pc_i(32'h1000 + 32'(drv_idx) * 4), .exp_areg_i(t_dst[drv_idx]),
    .exp_preg_i(t_preg[drv_idx]), .exp_old_preg_i(t_old[drv_idx]),
    .exp_old_valid_i(t_oldv[drv_idx]), .exp_excp_i(t_excp[drv_idx]),
    .exp_ecode_i(t_ecode[drv_idx]), .exp_issue_i(t_issue[drv_idx]),
    .exp_psrc0_i(t_ps0[drv_idx]), .exp_psrc1_i(t_ps1[drv_idx]),
    .exp_type_i(t_type[drv_idx]),
    .exp_wait_en_i(t_wait[drv_idx]), .exp_wait_preg_i(t_wpreg[drv_idx]),
    .tests_o(tests), .fails_o(fails), .errors_o(errors), .pending_o(pending)
  );

  // ====================
  // driving loop
  // ====================

  task automatic apply_entry(input int i);
    @(posedge clk);
    drv_idx   <= i;
    in_valid  <= 1'b1;
    in_pc     <= 32'h1000 + 32'(i) * 4;
    in_type   <= t_type[i];
    in_misc   <= t_misc[i];
    in_inv    <= t_inv[i];
    in_dst    <= t_dst[i];
    in_s0     <= t_s0[i];
    in_s1     <= t_s1[i];
    has_int   <= t_int[i];
    plv       <= t_plv[i];
    cur_rdyhi <= t_rdyhi[i];
    do @(posedge clk); while (!in_ready);
    in_valid  <= 1'b0;
    exp_valid <= 1'b1;
    @(posedge clk);
    exp_valid <= 1'b0;
    case (t_act[i])
      ACT_WB: begin
        wb_valid <= 1'b1;
        wb_preg  <= t_apreg[i];
        @(posedge clk);
        wb_valid <= 1'b0;
      end
      ACT_FREE: begin
        stall_chk <= 1'b1;
        repeat (4) @(posedge clk);
        stall_chk  <= 1'b0;
        free_valid <= 1'b1;
        free_preg  <= t_apreg[i];
        @(posedge clk);
        free_valid <= 1'b0;
      end
      ACT_FLUSH: begin
        while (pending != 0) @(negedge clk);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
      end
      default: ;
    endcase
    repeat (2) @(posedge clk);
  endtask

  initial begin
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      apply_entry(i);
    end
    while (pending != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("tests run %0d, failed %0d, errors %0d", tests, fails, errors);
    if (errors == 0 && fails == 0 && tests == N_TESTS && pending == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (N_TESTS * 40 + 200) @(posedge clk);
    $display("watchdog expired with %0d expected events still pending", pending);
    $display("tests failed");
    $finish;
  end

endmodule

// File: list.f
hw/sched_pkg.sv
hw/free_list.sv
hw/rename_table.sv
hw/excp_check.sv
hw/dispatch_queue.sv
hw/scheduler.sv
sim/sched_checker.sv
sim/tb_scheduler.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_scheduler \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
